//--- design/decode_pkg.sv
// Types and byte constants for the second decode stage of the integer core
// Covers one-byte opcodes only and carries no microcode control fields
// Byte lengths of displacement and immediate above 4 are read as 4
package decode_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_OR,
      ALU_AND,
      ALU_SUB,
      ALU_XOR,
      ALU_MOV,
      ALU_NOP,
      ALU_MOVS,
      ALU_ILLEGAL
   } alu_op_e;

   typedef enum logic [1:0] {OPND_NONE, OPND_REG, OPND_RM, OPND_IMM} opnd_e;
   typedef enum logic [1:0] {SZ_8, SZ_16, SZ_32} size_e;
   typedef enum logic [1:0] {STK_NONE, STK_PUSH, STK_POP} stack_op_e;

   // x86 segment register numbering
   typedef enum logic [2:0] {SEG_ES, SEG_CS, SEG_SS, SEG_DS, SEG_FS, SEG_GS} seg_e;

   // First prefix sits in prefix[23:16]
   typedef struct packed {
      logic [23:0] prefix;
      logic [1:0]  prefix_bytes;
      logic [7:0]  opcode;
      logic [7:0]  modrm;
      logic [7:0]  sib;
      logic [63:0] disp_n_imm;
      logic [2:0]  disp_bytes;
      logic [2:0]  imm_bytes;
   } s0_bundle_t;

   typedef struct packed {
      seg_e seg;
      logic seg_valid;
      logic rep;
      logic size_override;
   } prefix_info_t;

   typedef struct packed {
      alu_op_e     alu_op;
      opnd_e       op0;
      opnd_e       op1;
      size_e       size;
      logic [2:0]  op0_reg;
      logic [2:0]  op1_reg;
      logic [7:0]  modrm;
      logic [7:0]  sib;
      logic [31:0] imm;
      logic [31:0] disp;
      seg_e        seg;
      logic        seg_valid;
      stack_op_e   stack_op;
      logic        set_d_flag;
      logic        clear_d_flag;
   } decode_ctl_t;

   localparam logic [7:0] PFX_REP    = 8'hF3;
   localparam logic [7:0] PFX_OPSIZE = 8'h66;
   localparam logic [7:0] PFX_ES     = 8'h26;
   localparam logic [7:0] PFX_CS     = 8'h2E;
   localparam logic [7:0] PFX_SS     = 8'h36;
   localparam logic [7:0] PFX_DS     = 8'h3E;
   localparam logic [7:0] PFX_FS     = 8'h64;
   localparam logic [7:0] PFX_GS     = 8'h65;
   localparam logic [7:0] OPC_MOVS   = 8'hA5;

endpackage

//--- design/prefix_decode.sv
// Decodes up to three prefix bytes, first prefix in the top byte
// Unknown prefix bytes are ignored, REPNE is not recognized
`timescale 1ns/1ps

module prefix_decode import decode_pkg::*; (
   input  logic [23:0]  prefix,
   input  logic [1:0]   prefix_bytes,
   output prefix_info_t info
);

   always_comb begin
      logic [7:0] pb;
      seg_e       seg;
      logic       hit;

      info = '0;
      for (int i = 0; i < 3; i++) begin
         pb  = prefix[23 - 8*i -: 8];
         seg = SEG_DS;
         hit = 1'b1;
         case (pb)
            PFX_ES:  seg = SEG_ES;
            PFX_CS:  seg = SEG_CS;
            PFX_SS:  seg = SEG_SS;
            PFX_DS:  seg = SEG_DS;
            PFX_FS:  seg = SEG_FS;
            PFX_GS:  seg = SEG_GS;
            default: hit = 1'b0;
         endcase
         if (i < prefix_bytes) begin
            // Later segment prefixes overwrite earlier ones
            if (hit) begin
               info.seg       = seg;
               info.seg_valid = 1'b1;
            end
            if (pb == PFX_REP) begin
               info.rep = 1'b1;
            end
            if (pb == PFX_OPSIZE) begin
               info.size_override = 1'b1;
            end
         end
      end
   end

endmodule

//--- design/imm_disp_split.sv
// Splits the packed displacement and immediate bytes
// One-byte values are sign extended, longer ones zero extended, lengths above 4 read as 4
`timescale 1ns/1ps

module imm_disp_split (
   input  logic [63:0] disp_n_imm,
   input  logic [2:0]  disp_bytes,
   input  logic [2:0]  imm_bytes,
   output logic [31:0] disp,
   output logic [31:0] imm
);

   function automatic logic [31:0] extend(input logic [63:0] raw, input logic [2:0] n);
      logic [31:0] v;

      case (n)
         3'd0:    v = '0;
         3'd1:    v = {{24{raw[7]}}, raw[7:0]};
         3'd2:    v = {16'b0, raw[15:0]};
         3'd3:    v = {8'b0, raw[23:0]};
         default: v = raw[31:0];
      endcase
      return v;
   endfunction

   assign disp = extend(disp_n_imm, disp_bytes);

   // Immediate starts right after the displacement bytes
   assign imm = extend(disp_n_imm >> {disp_bytes, 3'b000}, imm_bytes);

endmodule

//--- design/op_decode.sv
// Maps a one-byte opcode and ModRM to the stage-1 control word
// Covers the basic ALU groups, MOV, PUSH, POP, flag ops, NOP and MOVS only
`timescale 1ns/1ps

module op_decode import decode_pkg::*; (
   input  s0_bundle_t   bundle,
   input  prefix_info_t info,
   input  logic [31:0]  disp,
   input  logic [31:0]  imm,
   output decode_ctl_t  ctl,
   output logic         is_movs
);

   logic [7:0] opc;
   logic [2:0] reg_f;
   logic [2:0] rm_f;
   logic       alu_grp;
   size_e      wide;

   assign opc   = bundle.opcode;
   assign reg_f = bundle.modrm[5:3];
   assign rm_f  = bundle.modrm[2:0];
   assign wide  = info.size_override ? SZ_16 : SZ_32;

   // ADD, OR, AND, SUB, XOR in forms 0 to 5
   assign alu_grp = (opc[7:6] == 2'b00) && (opc[2:1] != 2'b11) &&
                    (opc[5:3] inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6});

   always_comb begin
      logic rm_form;

      rm_form      = 1'b0;
      is_movs      = 1'b0;
      ctl          = '0;
      ctl.alu_op   = ALU_ILLEGAL;
      ctl.op0      = OPND_NONE;
      ctl.op1      = OPND_NONE;
      ctl.size     = wide;
      ctl.stack_op = STK_NONE;
      ctl.modrm    = bundle.modrm;
      ctl.sib      = bundle.sib;
      ctl.imm      = imm;
      ctl.disp     = disp;
      ctl.seg      = info.seg;
      ctl.seg_valid = info.seg_valid;

      casez (opc)
         8'b1000_10??: begin
            ctl.alu_op = ALU_MOV;
            rm_form    = 1'b1;
         end
         8'b0101_0???, 8'b0101_1???: begin
            ctl.alu_op   = ALU_MOV;
            ctl.op0      = OPND_REG;
            ctl.op0_reg  = opc[2:0];
            ctl.stack_op = opc[3] ? STK_POP : STK_PUSH;
         end
         8'b1011_1???: begin
            ctl.alu_op  = ALU_MOV;
            ctl.op0     = OPND_REG;
            ctl.op0_reg = opc[2:0];
            ctl.op1     = OPND_IMM;
         end
         8'hFC: begin
            ctl.alu_op       = ALU_NOP;
            ctl.clear_d_flag = 1'b1;
         end
         8'hFD: begin
            ctl.alu_op     = ALU_NOP;
            ctl.set_d_flag = 1'b1;
         end
         8'h90: ctl.alu_op = ALU_NOP;
         OPC_MOVS: begin
            ctl.alu_op = ALU_MOVS;
            is_movs    = 1'b1;
         end
         default: begin
            if (alu_grp) begin
               case (opc[5:3])
                  3'd0:    ctl.alu_op = ALU_ADD;
                  3'd1:    ctl.alu_op = ALU_OR;
                  3'd4:    ctl.alu_op = ALU_AND;
                  3'd5:    ctl.alu_op = ALU_SUB;
                  default: ctl.alu_op = ALU_XOR;
               endcase
               if (opc[2:1] == 2'b10) begin
                  // Accumulator with immediate
                  ctl.size = opc[0] ? wide : SZ_8;
                  ctl.op0  = OPND_REG;
                  ctl.op1  = OPND_IMM;
               end else begin
                  rm_form = 1'b1;
               end
            end
         end
      endcase

      // Bit 1 set means the register is the destination
      if (rm_form) begin
         ctl.size = opc[0] ? wide : SZ_8;
         if (opc[1]) begin
            ctl.op0     = OPND_REG;
            ctl.op0_reg = reg_f;
            ctl.op1     = OPND_RM;
            ctl.op1_reg = rm_f;
         end else begin
            ctl.op0     = OPND_RM;
            ctl.op0_reg = rm_f;
            ctl.op1     = OPND_REG;
            ctl.op1_reg = reg_f;
         end
      end
   end

   always_comb begin
      a_dflag_excl: assert final (!(ctl.set_d_flag && ctl.clear_d_flag))
         else $error("set_d_flag and clear_d_flag both high");
   end

endmodule

//--- design/repeat_control.sv
// REP MOVS sequencer, one issue per ECX count with a write-back of the new count
// Stage 0 is held until the last issue, ECX of zero retires with no issue
// Stage 0 must drop its instruction on flush
`timescale 1ns/1ps

module repeat_control (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        flush,
   input  logic        s0_valid,
   input  logic        rep,
   input  logic        is_movs,
   input  logic [31:0] ecx,
   input  logic        out_ready,
   output logic        issue_valid,
   output logic        s0_ready,
   output logic        wb_valid,
   output logic [31:0] wb_data
);

   typedef enum logic {RPT_IDLE, RPT_RUN} rpt_state_e;

   rpt_state_e  state;
   logic [31:0] count;
   logic [31:0] cur;
   logic        rep_movs;
   logic        last;

   assign rep_movs = s0_valid && rep && is_movs;

   // Remaining count before this issue
   assign cur  = (state == RPT_RUN) ? count : ecx;
   assign last = (cur == 32'd1);

   always_comb begin
      issue_valid = 1'b0;
      s0_ready    = 1'b0;
      if (!flush) begin
         if (state == RPT_RUN || rep_movs) begin
            issue_valid = (cur != '0);
            s0_ready    = (cur == '0) || (out_ready && last);
         end else begin
            issue_valid = s0_valid;
            s0_ready    = out_ready;
         end
      end
   end

   assign wb_valid = issue_valid && out_ready && (state == RPT_RUN || rep_movs);
   assign wb_data  = cur - 32'd1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= RPT_IDLE;
         count <= '0;
      end else if (flush) begin
         state <= RPT_IDLE;
      end else if (wb_valid) begin
         count <= wb_data;
         state <= last ? RPT_IDLE : RPT_RUN;
      end
   end

   a_run_count: assert property (@(posedge clk) disable iff (!rst_n)
      state == RPT_RUN |-> count != '0)
      else $error("repeat running with zero count");

endmodule

//--- design/decode_out_reg.sv
// One-entry stage-1 register with valid/ready handshake
// Flush empties the entry at the next edge and wins over a load
`timescale 1ns/1ps

module decode_out_reg import decode_pkg::*; #(
   parameter int IADDRW = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              flush,
   input  logic              in_valid,
   input  decode_ctl_t       in_ctl,
   input  logic [IADDRW-1:0] in_pc,
   output logic              out_ready,
   output logic              s1_valid,
   output decode_ctl_t       s1_ctl,
   output logic [IADDRW-1:0] s1_pc,
   input  logic              s1_ready
);

   assign out_ready = !s1_valid || s1_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else if (flush) begin
         s1_valid <= 1'b0;
      end else if (out_ready) begin
         s1_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && out_ready) begin
         s1_ctl <= in_ctl;
         s1_pc  <= in_pc;
      end
   end

   // Stalled item must not change or vanish
   a_s1_stable: assert property (@(posedge clk) disable iff (!rst_n)
      s1_valid && !s1_ready && !flush |=> s1_valid && $stable(s1_ctl) && $stable(s1_pc))
      else $error("stage-1 output changed while stalled");

endmodule

//--- design/decode_stage.sv
// Second decode stage top level
// The PC passes beside the control word, one item is held at the stage-1 output
`timescale 1ns/1ps

module decode_stage import decode_pkg::*; #(
   parameter int IADDRW = 32
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              flush,
   input  logic              s0_valid,
   output logic              s0_ready,
   input  s0_bundle_t        s0_bundle,
   input  logic [IADDRW-1:0] s0_pc,
   input  logic [31:0]       ecx,
   output logic              s1_valid,
   input  logic              s1_ready,
   output decode_ctl_t       s1_ctl,
   output logic [IADDRW-1:0] s1_pc,
   output logic              wb_valid,
   output logic [31:0]       wb_data
);

   prefix_info_t info;
   logic [31:0]  disp;
   logic [31:0]  imm;
   decode_ctl_t  ctl;
   logic         is_movs;
   logic         issue_valid;
   logic         out_ready;

   prefix_decode u_prefix (
      .prefix       (s0_bundle.prefix),
      .prefix_bytes (s0_bundle.prefix_bytes),
      .info         (info)
   );

   imm_disp_split u_split (
      .disp_n_imm (s0_bundle.disp_n_imm),
      .disp_bytes (s0_bundle.disp_bytes),
      .imm_bytes  (s0_bundle.imm_bytes),
      .disp       (disp),
      .imm        (imm)
   );

   op_decode u_op (
      .bundle  (s0_bundle),
      .info    (info),
      .disp    (disp),
      .imm     (imm),
      .ctl     (ctl),
      .is_movs (is_movs)
   );

   repeat_control u_rpt (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .s0_valid    (s0_valid),
      .rep         (info.rep),
      .is_movs     (is_movs),
      .ecx         (ecx),
      .out_ready   (out_ready),
      .issue_valid (issue_valid),
      .s0_ready    (s0_ready),
      .wb_valid    (wb_valid),
      .wb_data     (wb_data)
   );

   decode_out_reg #(.IADDRW(IADDRW)) u_out (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (issue_valid),
      .in_ctl    (ctl),
      .in_pc     (s0_pc),
      .out_ready (out_ready),
      .s1_valid  (s1_valid),
      .s1_ctl    (s1_ctl),
      .s1_pc     (s1_pc),
      .s1_ready  (s1_ready)
   );

endmodule

//--- sim/decode_stage_tb.sv
// Testbench for the second decode stage, table driven with random stage-1 back-pressure
// A flush entry cuts the REP MOVS before it short after its first issue
// Expected items carry their table index so a flush can drop the cut repeat
`timescale 1ns/1ps

module decode_stage_tb import decode_pkg::*; ();

   localparam int IADDRW      = 32;
   localparam int CLK_PERIOD  = 8;
   localparam int MAX_ENTRIES = 32;

   logic              clk;
   logic              rst_n;
   logic              flush;
   logic              s0_valid;
   logic              s0_ready;
   s0_bundle_t        s0_bundle;
   logic [IADDRW-1:0] s0_pc;
   logic [31:0]       ecx;
   logic              s1_valid;
   logic              s1_ready;
   decode_ctl_t       s1_ctl;
   logic [IADDRW-1:0] s1_pc;
   logic              wb_valid;
   logic [31:0]       wb_data;

   string             tbl_name[MAX_ENTRIES];
   s0_bundle_t        tbl_bundle[MAX_ENTRIES];
   logic [IADDRW-1:0] tbl_pc[MAX_ENTRIES];
   int                tbl_ecx[MAX_ENTRIES];
   bit                tbl_flush[MAX_ENTRIES];
   int                n_entries = 0;
   bit                table_loaded = 1'b0;

   decode_ctl_t       exp_ctl[$];
   logic [IADDRW-1:0] exp_pc[$];
   int                exp_tag[$];
   logic [31:0]       wb_exp[$];
   int                wb_tag[$];

   integer seed;
   int     ctl_errs = 0;
   int     pc_errs = 0;
   int     wb_errs = 0;
   int     other_errs = 0;

   decode_stage #(.IADDRW(IADDRW)) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .s0_valid  (s0_valid),
      .s0_ready  (s0_ready),
      .s0_bundle (s0_bundle),
      .s0_pc     (s0_pc),
      .ecx       (ecx),
      .s1_valid  (s1_valid),
      .s1_ready  (s1_ready),
      .s1_ctl    (s1_ctl),
      .s1_pc     (s1_pc),
      .wb_valid  (wb_valid),
      .wb_data   (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic s0_bundle_t bundle_of(input logic [23:0] pfx, input logic [1:0] npfx,
                                            input logic [7:0] opc, input logic [7:0] modrm,
                                            input logic [7:0] sib, input logic [63:0] bytes,
                                            input logic [2:0] nd, input logic [2:0] ni);
      s0_bundle_t b;

      b.prefix       = pfx;
      b.prefix_bytes = npfx;
      b.opcode       = opc;
      b.modrm        = modrm;
      b.sib          = sib;
      b.disp_n_imm   = bytes;
      b.disp_bytes   = nd;
      b.imm_bytes    = ni;
      return b;
   endfunction

   // Low n bytes of raw, a single byte sign extended
   function automatic logic [31:0] sized_value(input logic [63:0] raw, input int n);
      logic [31:0] v;

      v = '0;
      if (n == 1) begin
         v = {{24{raw[7]}}, raw[7:0]};
      end else begin
         for (int k = 0; k < 4 && k < n; k++) begin
            v[8*k +: 8] = raw[8*k +: 8];
         end
      end
      return v;
   endfunction

   function automatic decode_ctl_t rm_operands(input decode_ctl_t c, input logic [7:0] modrm,
                                               input logic to_reg);
      decode_ctl_t r;

      r = c;
      r.op0     = to_reg ? OPND_REG : OPND_RM;
      r.op0_reg = to_reg ? modrm[5:3] : modrm[2:0];
      r.op1     = to_reg ? OPND_RM : OPND_REG;
      r.op1_reg = to_reg ? modrm[2:0] : modrm[5:3];
      return r;
   endfunction

   function automatic bit rep_movs(input s0_bundle_t b);
      bit rep;

      rep = 1'b0;
      for (int i = 0; i < b.prefix_bytes; i++) begin
         if (b.prefix[23 - 8*i -: 8] == 8'hF3) rep = 1'b1;
      end
      return rep && (b.opcode == 8'hA5);
   endfunction

   function automatic decode_ctl_t expected_ctl(input s0_bundle_t b);
      decode_ctl_t c;
      logic [7:0]  p;
      logic [7:0]  o;
      logic        osz;

      c   = '0;
      osz = 1'b0;
      o   = b.opcode;
      for (int i = 0; i < b.prefix_bytes; i++) begin
         p = b.prefix[23 - 8*i -: 8];
         if (p == 8'h66) osz = 1'b1;
         if (p inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65}) c.seg_valid = 1'b1;
         case (p)
            8'h26: c.seg = SEG_ES;
            8'h2E: c.seg = SEG_CS;
            8'h36: c.seg = SEG_SS;
            8'h3E: c.seg = SEG_DS;
            8'h64: c.seg = SEG_FS;
            8'h65: c.seg = SEG_GS;
            default: ;
         endcase
      end
      c.modrm  = b.modrm;
      c.sib    = b.sib;
      c.disp   = sized_value(b.disp_n_imm, b.disp_bytes);
      c.imm    = sized_value(b.disp_n_imm >> (8 * b.disp_bytes), b.imm_bytes);
      c.size   = osz ? SZ_16 : SZ_32;
      c.alu_op = ALU_ILLEGAL;
      if (o[7:6] == 2'b00 && o[2:0] <= 3'd5 && o[5:3] inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6}) begin
         case (o[5:3])
            3'd0:    c.alu_op = ALU_ADD;
            3'd1:    c.alu_op = ALU_OR;
            3'd4:    c.alu_op = ALU_AND;
            3'd5:    c.alu_op = ALU_SUB;
            default: c.alu_op = ALU_XOR;
         endcase
         if (!o[0]) c.size = SZ_8;
         if (o[2]) begin
            c.op0 = OPND_REG;
            c.op1 = OPND_IMM;
         end else begin
            c = rm_operands(c, b.modrm, o[1]);
         end
      end else if (o[7:2] == 6'b100010) begin
         c.alu_op = ALU_MOV;
         if (!o[0]) c.size = SZ_8;
         c = rm_operands(c, b.modrm, o[1]);
      end else if (o[7:4] == 4'h5) begin
         c.alu_op   = ALU_MOV;
         c.op0      = OPND_REG;
         c.op0_reg  = o[2:0];
         c.stack_op = o[3] ? STK_POP : STK_PUSH;
      end else if (o[7:3] == 5'b10111) begin
         c.alu_op  = ALU_MOV;
         c.op0     = OPND_REG;
         c.op0_reg = o[2:0];
         c.op1     = OPND_IMM;
      end else if (o == 8'hFC || o == 8'hFD || o == 8'h90) begin
         c.alu_op       = ALU_NOP;
         c.clear_d_flag = (o == 8'hFC);
         c.set_d_flag   = (o == 8'hFD);
      end else if (o == 8'hA5) begin
         c.alu_op = ALU_MOVS;
      end
      return c;
   endfunction

   task automatic check_ctl(input string name, input decode_ctl_t exp, input decode_ctl_t act);
      if (act !== exp) begin
         ctl_errs++;
         $display("Mismatch %s ctl: expected %h (%s) actual %h (%s)", name, exp,
                  exp.alu_op.name(), act, act.alu_op.name());
      end
   endtask

   task automatic check_pc(input string name, input logic [IADDRW-1:0] exp,
                           input logic [IADDRW-1:0] act);
      if (act !== exp) begin
         pc_errs++;
         $display("Mismatch %s pc: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_wb(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         wb_errs++;
         $display("Mismatch %s wb_data: expected %0d actual %0d", name, exp, act);
      end
   endtask

   // Consumed items and write-backs, sampled mid-cycle where they are stable
   always @(negedge clk) begin
      if (rst_n && s1_valid && s1_ready && !flush) begin
         if (exp_ctl.size() == 0) begin
            other_errs++;
            $display("Unexpected stage-1 item with pc %h", s1_pc);
         end else begin
            check_ctl(tbl_name[exp_tag[0]], exp_ctl[0], s1_ctl);
            check_pc(tbl_name[exp_tag[0]], exp_pc[0], s1_pc);
            void'(exp_ctl.pop_front());
            void'(exp_pc.pop_front());
            void'(exp_tag.pop_front());
         end
      end
      if (rst_n && wb_valid) begin
         if (wb_exp.size() == 0) begin
            other_errs++;
            $display("Unexpected write-back of %0d", wb_data);
         end else begin
            check_wb(tbl_name[wb_tag[0]], wb_exp[0], wb_data);
            void'(wb_exp.pop_front());
            void'(wb_tag.pop_front());
         end
      end
   end

   task automatic add_entry(input string name, input logic [IADDRW-1:0] pc, input int ecx_val,
                            input bit flush_val, input s0_bundle_t b);
      tbl_name[n_entries]   = name;
      tbl_pc[n_entries]     = pc;
      tbl_ecx[n_entries]    = ecx_val;
      tbl_flush[n_entries]  = flush_val;
      tbl_bundle[n_entries] = b;
      n_entries++;
   endtask

   task automatic load_table();
      // name, pc, ecx, flush_before, then prefix, count, opcode, modrm, sib, bytes, nd, ni
      add_entry("add_rm8", 32'h1000, 0, 0,
                bundle_of(24'h0, 0, 8'h00, 8'hC1, 8'h00, 64'h0, 0, 0));
      add_entry("or_r32_disp8", 32'h1002, 0, 0,
                bundle_of(24'h0, 0, 8'h0B, 8'h5A, 8'h00, 64'h80, 1, 0));
      add_entry("and_al_imm8", 32'h1005, 0, 0,
                bundle_of(24'h0, 0, 8'h24, 8'h00, 8'h00, 64'hF0, 0, 1));
      add_entry("sub_ax_imm16", 32'h1007, 0, 0,
                bundle_of(24'h660000, 1, 8'h2D, 8'h00, 8'h00, 64'h8123, 0, 2));
      add_entry("xor_rm_r32", 32'h100B, 0, 0,
                bundle_of(24'h0, 0, 8'h31, 8'hD8, 8'h00, 64'h85_1234, 2, 1));
      add_entry("add_eax_imm32", 32'h100F, 0, 0,
                bundle_of(24'h0, 0, 8'h05, 8'h00, 8'h00, 64'hDEAD_BEEF, 0, 4));
      add_entry("sub_r8_rm", 32'h1014, 0, 0,
                bundle_of(24'h0, 0, 8'h2A, 8'hC3, 8'h00, 64'h0, 0, 0));
      add_entry("mov_rm_r8", 32'h1016, 0, 0,
                bundle_of(24'h0, 0, 8'h88, 8'h4B, 8'h00, 64'h10, 1, 0));
      add_entry("mov_r16_sib", 32'h1019, 0, 0,
                bundle_of(24'h660000, 1, 8'h8B, 8'h94, 8'h24, 64'h80, 1, 0));
      add_entry("mov_r32_imm", 32'h101E, 0, 0,
                bundle_of(24'h0, 0, 8'hBB, 8'h00, 8'h00, 64'h1234_5678, 0, 4));
      add_entry("mov_r16_imm", 32'h1023, 0, 0,
                bundle_of(24'h660000, 1, 8'hBE, 8'h00, 8'h00, 64'hFFEE, 0, 2));
      add_entry("seg_last_wins", 32'h1027, 0, 0,
                bundle_of(24'h26642E, 3, 8'h89, 8'hC1, 8'h00, 64'h0, 0, 0));
      add_entry("prefix_limit", 32'h102C, 0, 0,
                bundle_of(24'h3E6665, 1, 8'h01, 8'hC1, 8'h00, 64'h0, 0, 0));
      add_entry("rep_outside_count", 32'h1030, 4, 0,
                bundle_of(24'h26F300, 1, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("push_ebx", 32'h1032, 0, 0,
                bundle_of(24'h0, 0, 8'h53, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("pop_esi", 32'h1033, 0, 0,
                bundle_of(24'h0, 0, 8'h5E, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("cld", 32'h1034, 0, 0,
                bundle_of(24'h0, 0, 8'hFC, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("std", 32'h1035, 0, 0,
                bundle_of(24'h0, 0, 8'hFD, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("nop", 32'h1036, 0, 0,
                bundle_of(24'h0, 0, 8'h90, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("undef_0f", 32'h1037, 0, 0,
                bundle_of(24'h0, 0, 8'h0F, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("undef_3c", 32'h1039, 0, 0,
                bundle_of(24'h0, 0, 8'h3C, 8'h00, 8'h00, 64'h7F, 0, 1));
      add_entry("rep_movs_3", 32'h103B, 3, 0,
                bundle_of(24'hF30000, 1, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("rep_movs_1", 32'h103D, 1, 0,
                bundle_of(24'hF30000, 1, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("rep_movs_0", 32'h103F, 0, 0,
                bundle_of(24'hF30000, 1, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("rep_add", 32'h1041, 5, 0,
                bundle_of(24'hF30000, 1, 8'h01, 8'hC8, 8'h00, 64'h0, 0, 0));
      add_entry("all_prefix_movs", 32'h1044, 2, 0,
                bundle_of(24'h66F336, 3, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("rep_movs_cut", 32'h1048, 6, 0,
                bundle_of(24'hF30000, 1, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
      add_entry("after_flush", 32'h104A, 0, 1,
                bundle_of(24'h0, 0, 8'h29, 8'hC8, 8'h00, 64'h0, 0, 0));
      add_entry("movs_plain", 32'h104C, 9, 0,
                bundle_of(24'h0, 0, 8'hA5, 8'h00, 8'h00, 64'h0, 0, 0));
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
      // Stage 1 is ready about three cycles in four
      s1_ready = ($random(seed) & 3) != 0;
   endtask

   task automatic queue_expected(input int k);
      int n;

      n = rep_movs(tbl_bundle[k]) ? tbl_ecx[k] : 1;
      for (int i = 1; i <= n; i++) begin
         exp_ctl.push_back(expected_ctl(tbl_bundle[k]));
         exp_pc.push_back(tbl_pc[k]);
         exp_tag.push_back(k);
         if (rep_movs(tbl_bundle[k])) begin
            wb_exp.push_back(n - i);
            wb_tag.push_back(k);
         end
      end
   endtask

   // Items of a cut repeat that will never reach stage 1
   task automatic drop_pending(input int tag);
      while (exp_tag.size() != 0 && exp_tag[$] == tag) begin
         void'(exp_ctl.pop_back());
         void'(exp_pc.pop_back());
         void'(exp_tag.pop_back());
      end
      while (wb_tag.size() != 0 && wb_tag[$] == tag) begin
         void'(wb_exp.pop_back());
         void'(wb_tag.pop_back());
      end
   endtask

   task automatic run_entry(input int k);
      bit cut;
      bit done;
      int issued;

      if (tbl_flush[k]) begin
         flush    = 1'b1;
         s0_valid = 1'b0;
         s1_ready = 1'b0;
         drop_pending(k - 1);
         next_cycle();
         flush = 1'b0;
      end
      s0_bundle = tbl_bundle[k];
      s0_pc     = tbl_pc[k];
      ecx       = tbl_ecx[k];
      s0_valid  = 1'b1;
      queue_expected(k);
      cut    = (k + 1 < n_entries) && tbl_flush[k + 1];
      issued = 0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (wb_valid) issued++;
         if (s0_ready || (cut && issued > 0)) done = 1'b1;
         next_cycle();
      end
      s0_valid = 1'b0;
   endtask

   initial begin : watchdog
      int limit;

      wait (table_loaded);
      limit = 10;
      for (int k = 0; k < n_entries; k++) begin
         limit += 40 + 8 * tbl_ecx[k];
      end
      #(limit * CLK_PERIOD);
      $display("Timeout after %0d cycles, the run did not finish", limit);
      $display("Verification failed");
      $finish;
   end

   initial begin : main
      int total;

      seed      = 73346;
      rst_n     = 1'b0;
      flush     = 1'b0;
      s0_valid  = 1'b0;
      s0_bundle = '0;
      s0_pc     = '0;
      ecx       = '0;
      s1_ready  = 1'b0;
      load_table();
      table_loaded = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      if (s1_valid !== 1'b0 || wb_valid !== 1'b0 || s0_ready !== 1'b1) begin
         other_errs++;
         $display("Outputs after reset are not idle with s0_ready high");
      end
      next_cycle();
      for (int k = 0; k < n_entries; k++) begin
         run_entry(k);
      end
      while (exp_ctl.size() != 0) begin
         next_cycle();
      end
      s1_ready = 1'b1;
      repeat (4) @(posedge clk);
      if (wb_exp.size() != 0) begin
         other_errs++;
         $display("%0d expected write-backs never arrived", wb_exp.size());
      end
      total = ctl_errs + pc_errs + wb_errs + other_errs;
      $display("Errors: ctl %0d, pc %0d, wb %0d, other %0d", ctl_errs, pc_errs, wb_errs,
               other_errs);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- all.f
design/decode_pkg.sv
design/prefix_decode.sv
design/imm_disp_split.sv
design/op_decode.sv
design/repeat_control.sv
design/decode_out_reg.sv
design/decode_stage.sv
sim/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/decode_pkg.sv
  - design/prefix_decode.sv
  - design/imm_disp_split.sv
  - design/op_decode.sv
  - design/repeat_control.sv
  - design/decode_out_reg.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - sim/decode_stage_tb.sv
